/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f vlog.f \
    --top-module miniCoreTb -o miniCoreSim \
    && ./obj_dir/miniCoreSim \
    || exit 1

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    execCtrlIf.dp               ctrl,
    input  corePkg::dataWord_t  readDataA,
    input  corePkg::dataWord_t  readDataB,
    output corePkg::dataWord_t  result,
    output logic                isZero
);

    corePkg::dataWord_t regOpResult;

    // register form, A is the destination register and B the source register
    always_comb begin
        case (ctrl.aluFunc)
            isaPkg::FN_ADD : regOpResult = readDataA + readDataB;
            isaPkg::FN_INC : regOpResult = readDataB + 1'b1;
            isaPkg::FN_DEC : regOpResult = readDataB - 1'b1;
            isaPkg::FN_AND : regOpResult = readDataA & readDataB;
            isaPkg::FN_MOV : regOpResult = readDataB;
            // unknown function codes write the destination back unchanged
            default        : regOpResult = readDataA;
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            isaPkg::OP_ALU : result = regOpResult;
            // LLI clears the upper byte
            isaPkg::OP_LLI : result = {8'h00, ctrl.imm};
            // LUI only replaces the upper byte, so LLI then LUI builds a full word
            isaPkg::OP_LUI : result = {ctrl.imm, readDataA[7:0]};
            default        : result = readDataA;
        endcase
    end

    // branch condition for BZI, taken on the tested register being zero
    assign isZero = (readDataA == '0);

endmodule

/* src/corePkg.sv */
package corePkg;

    // widths of the core side, the port address shares the instruction address width
    localparam int dataWidth = 16;
    localparam int addrWidth = 10;

    // register contents and port data
    typedef logic [dataWidth-1:0] dataWord_t;

    // instruction address and output port address
    typedef logic [addrWidth-1:0] romAddr_t;

    // every instruction spends one cycle in FETCH and one in EXECUTE
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        FETCH   = 2'd1,
        EXECUTE = 2'd2,
        HALTED  = 2'd3
    } seqState_t;

endpackage

/* src/execCtrlIf.sv */
`timescale 1ns/1ps

// decoded controls of the instruction in EXECUTE, shared by the register file and the ALU
interface execCtrlIf;

    // write-back enable, only ever high during EXECUTE
    logic              regWrite;
    isaPkg::regIdx_t   writeIdx;

    // port A reads the destination register, port B the source register
    isaPkg::regIdx_t   readIdxA;
    isaPkg::regIdx_t   readIdxB;

    isaPkg::opcode_t   aluOp;
    isaPkg::aluFunc_t  aluFunc;
    isaPkg::imm8_t     imm;

    // the sequencer owns every control
    modport seq (
        output regWrite, writeIdx, readIdxA, readIdxB, aluOp, aluFunc, imm
    );

    // the datapath modules only look at them
    modport dp (
        input regWrite, writeIdx, readIdxA, readIdxB, aluOp, aluFunc, imm
    );

endinterface

/* src/instructionRom.sv */
`timescale 1ns/1ps

module instructionRom (
    input  corePkg::romAddr_t   address,
    output isaPkg::instrWord_t  value
);

    isaPkg::instrWord_t romWord;

    // the program writes eight Fibonacci numbers, an AND result and a zero read through r0
    always_comb begin : romTable
        case (address)
            // port address 0x18C into r1
            10'h000 : romWord = 16'hC18C; // LLI r1 'h8C
            10'h001 : romWord = 16'hE101; // LUI r1 'h01
            // seed values and the pass counter
            10'h002 : romWord = 16'hCA01; // LLI rA 'h01
            10'h003 : romWord = 16'hCB00; // LLI rB 'h00
            10'h004 : romWord = 16'hC908; // LLI r9 'h08
            // loop head, the current value goes out before the next one is formed
            10'h005 : romWord = 16'h3A51; // STW rA r1
            10'h006 : romWord = 16'h0C7A; // MOV rC rA
            10'h007 : romWord = 16'h0A0B; // ADD rA rB
            10'h008 : romWord = 16'h0B7C; // MOV rB rC
            10'h009 : romWord = 16'h0939; // DEC r9 r9
            10'h00A : romWord = 16'hB902; // BZI r9 [+2] leaves after the eighth pass
            10'h00B : romWord = 16'hB0FA; // BZI r0 [-6] back to the loop head
            // 0x1234 masked with 0x00FF leaves 0x0034
            10'h00C : romWord = 16'hC434; // LLI r4 'h34
            10'h00D : romWord = 16'hE412; // LUI r4 'h12
            10'h00E : romWord = 16'hC7FF; // LLI r7 'hFF
            10'h00F : romWord = 16'h0447; // AND r4 r7
            10'h010 : romWord = 16'hC288; // LLI r2 'h88
            10'h011 : romWord = 16'hE201; // LUI r2 'h01
            10'h012 : romWord = 16'h3452; // STW r4 r2
            // r0 reads as zero, so r5 must go out as zero
            10'h013 : romWord = 16'h0570; // MOV r5 r0
            10'h014 : romWord = 16'h3551; // STW r5 r1
            10'h015 : romWord = 16'h20E7; // RST
            default : romWord = 16'h0000;
        endcase
    end

    assign value = romWord;

endmodule

/* src/isaPkg.sv */
package isaPkg;

    // one instruction word as fetched from the program ROM
    typedef logic [15:0] instrWord_t;

    // register index and 8-bit immediate or signed branch offset
    typedef logic [3:0] regIdx_t;
    typedef logic [7:0] imm8_t;

    // major opcode in the top nibble, limited to the subset this core runs
    typedef enum logic [3:0] {
        OP_ALU = 4'h0,
        OP_RST = 4'h2,
        OP_STW = 4'h3,
        OP_BZI = 4'hB,
        OP_LLI = 4'hC,
        OP_LUI = 4'hE
    } opcode_t;

    // function field of the register form, opcode 0x0
    typedef enum logic [3:0] {
        FN_ADD = 4'h0,
        FN_INC = 4'h1,
        FN_DEC = 4'h3,
        FN_AND = 4'h4,
        FN_MOV = 4'h7
    } aluFunc_t;

    // opcode 0x3 shares its top nibble with the loads, the function field picks the store
    localparam logic [3:0] stwFunc = 4'h5;

    // field positions inside the instruction word
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 12;
    localparam int rdMsb     = 11;
    localparam int rdLsb     = 8;
    localparam int funcMsb   = 7;
    localparam int funcLsb   = 4;
    localparam int rsMsb     = 3;
    localparam int rsLsb     = 0;
    localparam int immMsb    = 7;
    localparam int immLsb    = 0;

    // unknown opcodes pass through unchanged and fall into the no-op branch of the decoder
    function automatic opcode_t getOpcode(instrWord_t word);
        return opcode_t'(word[opcodeMsb:opcodeLsb]);
    endfunction

    // destination register, also the tested register of BZI and the data register of STW
    function automatic regIdx_t getRd(instrWord_t word);
        return word[rdMsb:rdLsb];
    endfunction

    function automatic logic [3:0] getFunc(instrWord_t word);
        return word[funcMsb:funcLsb];
    endfunction

    // source register, also the address register of STW
    function automatic regIdx_t getRs(instrWord_t word);
        return word[rsMsb:rsLsb];
    endfunction

    function automatic imm8_t getImm(instrWord_t word);
        return word[immMsb:immLsb];
    endfunction

endpackage

/* src/miniCoreTop.sv */
`timescale 1ns/1ps

module miniCoreTop #(
    parameter corePkg::romAddr_t resetVector = '0
) (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                start,
    output logic                portWrite,
    output corePkg::romAddr_t   portAddr,
    output corePkg::dataWord_t  portData,
    output logic                halted
);

    corePkg::romAddr_t   pc;
    isaPkg::instrWord_t  instr;
    logic                pcInc;
    logic                pcLoad;
    logic                isZero;
    corePkg::dataWord_t  readDataA;
    corePkg::dataWord_t  readDataB;
    corePkg::dataWord_t  result;

    execCtrlIf execCtrl ();

    instructionRom instructionRom_inst (
        .address (pc),
        .value   (instr)
    );

    programCounter #(
        .resetVector (resetVector)
    ) programCounter_inst (
        .Clk    (Clk),
        .arstN  (arstN),
        .pcInc  (pcInc),
        .pcLoad (pcLoad),
        .offset (execCtrl.imm),
        .pc     (pc)
    );

    sequencerFsm sequencerFsm_inst (
        .Clk       (Clk),
        .arstN     (arstN),
        .start     (start),
        .instr     (instr),
        .isZero    (isZero),
        .pcInc     (pcInc),
        .pcLoad    (pcLoad),
        .ctrl      (execCtrl.seq),
        .portWrite (portWrite),
        .halted    (halted)
    );

    registerFile registerFile_inst (
        .Clk       (Clk),
        .arstN     (arstN),
        .ctrl      (execCtrl.dp),
        .result    (result),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    aluUnit aluUnit_inst (
        .ctrl      (execCtrl.dp),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .result    (result),
        .isZero    (isZero)
    );

    // STW puts the data register on port A and the address register on port B
    assign portData = readDataA;
    assign portAddr = readDataB[corePkg::addrWidth-1:0];

endmodule

/* src/programCounter.sv */
`timescale 1ns/1ps

module programCounter #(
    parameter corePkg::romAddr_t resetVector = '0
) (
    input  logic               Clk,
    input  logic               arstN,
    input  logic               pcInc,
    input  logic               pcLoad,
    input  isaPkg::imm8_t      offset,
    output corePkg::romAddr_t  pc
);

    corePkg::romAddr_t pcReg;
    corePkg::romAddr_t branchTarget;

    // the offset is relative to the branch itself, pc still points at it during EXECUTE
    assign branchTarget = pcReg + {{2{offset[7]}}, offset};

    // both paths wrap at ten bits through the width of romAddr_t
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= resetVector;
        end else if (pcLoad) begin
            pcReg <= branchTarget;
        end else if (pcInc) begin
            pcReg <= pcReg + 1'b1;
        end
    end

    assign pc = pcReg;

    // a taken branch must not also advance the counter
    pcStepExclusive : assert property (
        @(posedge Clk) disable iff (!arstN)
        !(pcInc && pcLoad)
    ) else $error("programCounter got pcInc and pcLoad in the same cycle");

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                Clk,
    input  logic                arstN,
    execCtrlIf.dp               ctrl,
    input  corePkg::dataWord_t  result,
    output corePkg::dataWord_t  readDataA,
    output corePkg::dataWord_t  readDataB
);

    corePkg::dataWord_t regs [16];

    // write-back happens at the end of EXECUTE and r0 keeps its reset value forever
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (ctrl.writeIdx != '0)) begin
            regs[ctrl.writeIdx] <= result;
        end
    end

    // both reads are combinational so the ALU sees operands in the same cycle
    assign readDataA = regs[ctrl.readIdxA];
    assign readDataB = regs[ctrl.readIdxB];

    // r0 holds zero in every cycle out of reset
    r0StaysZero : assert property (
        @(posedge Clk) disable iff (!arstN)
        regs[0] == '0
    ) else $error("register r0 is not zero");

endmodule

/* src/sequencerFsm.sv */
`timescale 1ns/1ps

module sequencerFsm (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                start,
    input  isaPkg::instrWord_t  instr,
    input  logic                isZero,
    output logic                pcInc,
    output logic                pcLoad,
    execCtrlIf.seq              ctrl,
    output logic                portWrite,
    output logic                halted
);

    corePkg::seqState_t  state;
    corePkg::seqState_t  nextState;
    isaPkg::instrWord_t  instrReg;
    isaPkg::opcode_t     opcode;
    logic                inExecute;
    logic                isStore;
    logic                writesReg;
    logic                branchTaken;

    // start only counts in IDLE and only reset leaves HALTED
    always_comb begin
        nextState = state;
        case (state)
            corePkg::IDLE    : if (start) nextState = corePkg::FETCH;
            corePkg::FETCH   : nextState = corePkg::EXECUTE;
            corePkg::EXECUTE : begin
                if (opcode == isaPkg::OP_RST) begin
                    nextState = corePkg::HALTED;
                end else begin
                    nextState = corePkg::FETCH;
                end
            end
            corePkg::HALTED  : nextState = corePkg::HALTED;
            default          : nextState = corePkg::IDLE;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= corePkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    // the instruction register holds the word for the whole EXECUTE cycle
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            instrReg <= '0;
        end else if (state == corePkg::FETCH) begin
            instrReg <= instr;
        end
    end

    // anything outside the known opcodes writes nothing and only advances pc
    assign opcode      = isaPkg::getOpcode(instrReg);
    assign inExecute   = (state == corePkg::EXECUTE);
    assign isStore     = (opcode == isaPkg::OP_STW) &&
                         (isaPkg::getFunc(instrReg) == isaPkg::stwFunc);
    assign writesReg   = (opcode == isaPkg::OP_ALU) || (opcode == isaPkg::OP_LLI) ||
                         (opcode == isaPkg::OP_LUI);
    // isZero looks at port A, which carries the tested register of BZI
    assign branchTaken = (opcode == isaPkg::OP_BZI) && isZero;

    // operand fields follow the instruction register and only the write enable is gated
    assign ctrl.regWrite = inExecute && writesReg;
    assign ctrl.writeIdx = isaPkg::getRd(instrReg);
    assign ctrl.readIdxA = isaPkg::getRd(instrReg);
    assign ctrl.readIdxB = isaPkg::getRs(instrReg);
    assign ctrl.aluOp    = opcode;
    assign ctrl.aluFunc  = isaPkg::aluFunc_t'(isaPkg::getFunc(instrReg));
    assign ctrl.imm      = isaPkg::getImm(instrReg);

    assign pcLoad    = inExecute && branchTaken;
    assign pcInc     = inExecute && !branchTaken;
    assign portWrite = inExecute && isStore;
    assign halted    = (state == corePkg::HALTED);

    // a store strobe comes in the cycle right after FETCH and never lasts into the next one
    portWriteOneCycle : assert property (
        @(posedge Clk) disable iff (!arstN)
        portWrite |-> ($past(state) == corePkg::FETCH) ##1 !portWrite
    ) else $error("portWrite not right after FETCH or longer than one cycle");

    // nothing but reset brings the core out of HALTED
    haltedSticky : assert property (
        @(posedge Clk) disable iff (!arstN)
        halted |=> halted
    ) else $error("halted dropped without a reset");

endmodule

/* tests/miniCoreTb.sv */
`timescale 1ns/1ps

module miniCoreTb;

    // cycle limits for each kind of wait
    localparam int writeTimeout = 100;
    localparam int haltTimeout  = 20;
    localparam int haltWatch    = 50;

    logic                Clk;
    logic                arstN;
    logic                start;
    logic                portWrite;
    corePkg::romAddr_t   portAddr;
    corePkg::dataWord_t  portData;
    logic                halted;

    // expected port writes in the order the program issues them
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];

    miniCoreTop #(
        .resetVector ('0)
    ) miniCoreTop_inst (
        .Clk       (Clk),
        .arstN     (arstN),
        .start     (start),
        .portWrite (portWrite),
        .portAddr  (portAddr),
        .portData  (portData),
        .halted    (halted)
    );

    // 8 ns period, inputs change and outputs are sampled on the falling edge
    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", testName, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // comment lines start with '#', the halt line closes the list
    task automatic loadExpected();
        int          fd;
        int          code;
        int          fields;
        string       line;
        logic [31:0] addr;
        logic [31:0] data;
        bit          sawHalt;
        sawHalt = 1'b0;
        fd = $fopen("tests/programInput.txt", "r");
        if (fd == 0) begin
            abortRun("could not open tests/programInput.txt");
        end
        code = $fgets(line, fd);
        while (code != 0 && !sawHalt) begin
            if (line.len() >= 4 && line.substr(0, 3) == "halt") begin
                sawHalt = 1'b1;
            end else if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h", addr, data);
                if (fields != 2) begin
                    abortRun("a line in tests/programInput.txt is not an address and data pair");
                end
                expAddr.push_back(addr);
                expData.push_back(data);
            end
            code = $fgets(line, fd);
        end
        $fclose(fd);
        if (!sawHalt || expAddr.size() == 0) begin
            abortRun("tests/programInput.txt holds no writes or lacks the halt line");
        end
    endtask

    // two full cycles of reset, the core must be quiet while it is held
    task automatic applyReset();
        @(negedge Clk);
        arstN = 1'b0;
        start = 1'b0;
        repeat (2) @(negedge Clk);
        checkValue("reset portWrite", 32'd0, 32'(portWrite));
        checkValue("reset halted", 32'd0, 32'(halted));
        arstN = 1'b1;
    endtask

    // nothing may happen in IDLE before start arrives
    task automatic idleGap(input int cycles);
        int i;
        checkValue("idle portWrite", 32'd0, 32'(portWrite));
        checkValue("idle halted", 32'd0, 32'(halted));
        for (i = 0; i < cycles; i++) begin
            @(negedge Clk);
            checkValue("idle portWrite", 32'd0, 32'(portWrite));
            checkValue("idle halted", 32'd0, 32'(halted));
        end
    endtask

    task automatic pulseStart();
        start = 1'b1;
        @(negedge Clk);
        start = 1'b0;
    endtask

    // every strobe is matched against the next pair and must drop after one cycle
    task automatic runProgram(input string passName);
        int    idx;
        int    waited;
        string tag;
        for (idx = 0; idx < expAddr.size(); idx++) begin
            waited = 0;
            while (portWrite !== 1'b1) begin
                if (waited >= writeTimeout) begin
                    abortRun($sformatf("port write %0d never came in the %s", idx, passName));
                end
                checkValue({passName, " halted before the last write"}, 32'd0, 32'(halted));
                @(negedge Clk);
                waited++;
            end
            tag = $sformatf("%s write %0d", passName, idx);
            checkValue({tag, " address"}, expAddr[idx], 32'(portAddr));
            checkValue({tag, " data"}, expData[idx], 32'(portData));
            @(negedge Clk);
            checkValue({tag, " strobe width"}, 32'd0, 32'(portWrite));
        end
    endtask

    // RST follows the last store, no further store may slip in before it
    task automatic awaitHalt(input string passName);
        int waited;
        waited = 0;
        while (halted !== 1'b1) begin
            if (waited >= haltTimeout) begin
                abortRun($sformatf("halted never rose after the last write in the %s", passName));
            end
            checkValue({passName, " extra write before halt"}, 32'd0, 32'(portWrite));
            @(negedge Clk);
            waited++;
        end
    endtask

    // the core stays halted and silent, start pulses here must be ignored
    task automatic watchHalted();
        int i;
        for (i = 0; i < haltWatch; i++) begin
            start = ((i % 10) == 5);
            @(negedge Clk);
            checkValue("write while halted", 32'd0, 32'(portWrite));
            checkValue("halted held", 32'd1, 32'(halted));
        end
        start = 1'b0;
    endtask

    initial begin
        int gap;
        arstN = 1'b0;
        start = 1'b0;
        void'($urandom(32'h4b356886));
        loadExpected();

        gap = $urandom_range(20, 0);
        applyReset();
        idleGap(gap);
        pulseStart();
        runProgram("first run");
        awaitHalt("first run");
        watchHalted();

        // a fresh reset must bring back IDLE and the same write sequence
        gap = $urandom_range(20, 0);
        applyReset();
        idleGap(gap);
        pulseStart();
        runProgram("second run");
        awaitHalt("second run");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* tests/programInput.txt */
# columns: port address (hex), port data (hex), one expected write per line
# the closing halt line marks the RST that follows the last write
18C 0001
18C 0001
18C 0002
18C 0003
18C 0005
18C 0008
18C 000D
18C 0015
188 0034
18C 0000
halt

/* vlog.f */
src/isaPkg.sv
src/corePkg.sv
src/execCtrlIf.sv
src/instructionRom.sv
src/programCounter.sv
src/sequencerFsm.sv
src/registerFile.sv
src/aluUnit.sv
src/miniCoreTop.sv
tests/miniCoreTb.sv
